// File: common/accel_regs_pkg.sv
package accel_regs_pkg;

  // Register port data word
  typedef logic [31:0] io_word_t;

  localparam int IO_STRB_WIDTH = $bits(io_word_t) / 8;

  // Descriptor registers
  localparam logic [11:0] REG_CMD  = 12'h000;
  localparam logic [11:0] REG_LEN  = 12'h004;
  localparam logic [11:0] REG_ADDR = 12'h008;

  // Hash registers, all with bit 8 set
  localparam logic [11:0] REG_HASH_CLR = 12'h100;
  localparam logic [11:0] REG_HASH_1B  = 12'h104;
  localparam logic [11:0] REG_HASH_2B  = 12'h108;
  localparam logic [11:0] REG_HASH_4B  = 12'h10C;

  // Any read with this bit set returns the hash value
  localparam int HASH_SEL_BIT = 8;

  // Command write bits
  localparam int CMD_START_BIT = 0;
  localparam int CMD_STOP_BIT  = 4;

  // Status bits in a command read
  localparam int STAT_BUSY_BIT  = 1;
  localparam int STAT_DONE_BIT  = 8;
  localparam int STAT_MATCH_BIT = 9;

endpackage

// File: common/accel_stream_pkg.sv
package accel_stream_pkg;

  // Byte length of one descriptor
  localparam int LEN_WIDTH = 14;

  // Signatures, oldest byte in the top byte
  localparam int SIG_COUNT = 4;
  localparam logic [SIG_COUNT-1:0][31:0] SIG_TABLE = '{
    32'h4745_5420,  // "GET "
    32'h504f_5354,  // "POST"
    32'h4854_5450,  // "HTTP"
    32'h1603_0100   // TLS handshake record
  };

  localparam int HASH_WIDTH = 32;

  // Standard RSS key, first key bit is bit 319
  localparam int KEY_WIDTH = 320;
  localparam logic [KEY_WIDTH-1:0] TOEPLITZ_KEY = {
    32'h6d5a_56da, 32'h255b_0ec2, 32'h4167_253d, 32'h43a3_8fb0,
    32'hd0ca_2bcb, 32'hae7b_30b4, 32'h77cb_2da3, 32'h8030_f20c,
    32'h6a42_b73b, 32'hbeac_01fa
  };

endpackage

// File: hw/accel_ctrl_regs.sv
module accel_ctrl_regs #(
  parameter int MEM_ADDR_WIDTH = 8,
  parameter int IO_ADDR_WIDTH  = 9
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    io_en,
  input  logic                                    io_wen,
  input  logic [accel_regs_pkg::IO_STRB_WIDTH-1:0] io_strb,
  input  logic [IO_ADDR_WIDTH-1:0]                io_addr,
  input  accel_regs_pkg::io_word_t                io_wr_data,
  output accel_regs_pkg::io_word_t                io_rd_data,
  output logic                                    io_rd_valid,
  output logic [MEM_ADDR_WIDTH-1:0]               desc_addr,
  output logic [accel_stream_pkg::LEN_WIDTH-1:0]  desc_len,
  output logic                                    desc_valid,
  output logic                                    desc_stop,
  output logic                                    sme_init,
  input  logic                                    dma_busy,
  input  logic                                    stream_done,
  input  logic                                    match_found,
  output logic [31:0]                             hash_data,
  output logic [1:0]                              hash_len,
  output logic                                    hash_valid,
  output logic                                    hash_clear,
  input  logic [accel_stream_pkg::HASH_WIDTH-1:0] hash_out
);

  logic [11:0] addr_w;
  logic wr, rd, hash_sel, cmd_wr, start_wr, stop_wr;
  logic hash_stall, done;
  accel_regs_pkg::io_word_t rd_word;

  // Word-aligned offset
  assign addr_w   = 12'({io_addr[IO_ADDR_WIDTH-1:2], 2'b00});
  assign wr       = io_en && io_wen;
  assign rd       = io_en && !io_wen;
  assign hash_sel = io_addr[accel_regs_pkg::HASH_SEL_BIT];
  assign cmd_wr   = wr && addr_w == accel_regs_pkg::REG_CMD && io_strb[0];
  assign start_wr = cmd_wr && io_wr_data[accel_regs_pkg::CMD_START_BIT];
  assign stop_wr  = cmd_wr && io_wr_data[accel_regs_pkg::CMD_STOP_BIT];

  always_comb begin
    rd_word = '0;
    if (hash_sel) begin
      rd_word = hash_out;
    end else begin
      case (addr_w)
        accel_regs_pkg::REG_CMD: begin
          rd_word[accel_regs_pkg::STAT_BUSY_BIT]  = dma_busy;
          rd_word[accel_regs_pkg::STAT_DONE_BIT]  = done;
          rd_word[accel_regs_pkg::STAT_MATCH_BIT] = match_found;
        end
        accel_regs_pkg::REG_LEN:  rd_word = 32'(desc_len);
        accel_regs_pkg::REG_ADDR: rd_word = 32'(desc_addr);
        default:                  rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid  <= 1'b0;
      desc_stop   <= 1'b0;
      sme_init    <= 1'b0;
      hash_valid  <= 1'b0;
      hash_clear  <= 1'b0;
      hash_stall  <= 1'b0;
      io_rd_valid <= 1'b0;
      done        <= 1'b0;
    end else begin
      desc_valid <= start_wr;
      sme_init   <= start_wr;
      desc_stop  <= stop_wr;
      hash_valid <= wr && (addr_w == accel_regs_pkg::REG_HASH_1B ||
                           addr_w == accel_regs_pkg::REG_HASH_2B ||
                           addr_w == accel_regs_pkg::REG_HASH_4B);
      hash_clear <= wr && addr_w == accel_regs_pkg::REG_HASH_CLR;
      // Hash value lags a data write by one cycle
      hash_stall  <= rd && hash_sel && hash_valid;
      io_rd_valid <= (rd && !(hash_sel && hash_valid)) || hash_stall;
      if (start_wr) begin
        done <= 1'b0;
      end else if (stream_done || desc_stop) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr && addr_w == accel_regs_pkg::REG_LEN) begin
      desc_len <= io_wr_data[accel_stream_pkg::LEN_WIDTH-1:0];
    end
    if (wr && addr_w == accel_regs_pkg::REG_ADDR) begin
      desc_addr <= io_wr_data[MEM_ADDR_WIDTH-1:0];
    end
    if (wr && hash_sel) begin
      hash_data <= io_wr_data;
      hash_len  <= (addr_w == accel_regs_pkg::REG_HASH_1B) ? 2'd1 :
                   (addr_w == accel_regs_pkg::REG_HASH_2B) ? 2'd2 : 2'd0;
    end
    if (hash_stall) begin
      io_rd_data <= hash_out;
    end else if (rd) begin
      io_rd_data <= rd_word;
    end
  end

endmodule

// File: dma/accel_rd_dma.sv
module accel_rd_dma #(
  parameter int DATA_WIDTH     = 128,
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [MEM_ADDR_WIDTH-1:0]              desc_addr,
  input  logic [accel_stream_pkg::LEN_WIDTH-1:0] desc_len,
  input  logic                                   desc_valid,
  input  logic                                   desc_stop,
  output logic                                   dma_busy,
  output logic                                   mem_rd_en,
  output logic [MEM_ADDR_WIDTH-1:0]              mem_rd_addr,
  input  logic [DATA_WIDTH-1:0]                  mem_rd_data,
  output logic [DATA_WIDTH-1:0]                  line_data,
  output logic [$clog2(DATA_WIDTH/8):0]          line_count,
  output logic                                   line_last,
  output logic                                   line_valid,
  input  logic                                   line_ready
);

  localparam int BYTES     = DATA_WIDTH / 8;
  localparam int CNT_WIDTH = $clog2(BYTES) + 1;
  localparam int LW        = accel_stream_pkg::LEN_WIDTH;

  logic [LW-1:0] remaining, cur_len;
  logic [MEM_ADDR_WIDTH-1:0] next_addr, cur_addr;
  logic [CNT_WIDTH-1:0] issue_bytes, rd_count;
  logic rd_last, issue, push, pop;
  logic [2:0] fill;

  // Two-entry skid buffer
  logic [DATA_WIDTH-1:0] buf_data [2];
  logic [CNT_WIDTH-1:0]  buf_count [2];
  logic                  buf_last [2];
  logic [1:0] occ;
  logic wr_ptr, rd_ptr;

  // A new descriptor issues its first read right away
  assign cur_len     = desc_valid ? desc_len : remaining;
  assign cur_addr    = desc_valid ? desc_addr : next_addr;
  assign issue_bytes = (cur_len > LW'(BYTES)) ? CNT_WIDTH'(BYTES) : CNT_WIDTH'(cur_len);
  assign push        = mem_rd_en && !desc_stop;
  assign pop         = line_valid && line_ready;
  assign fill        = 3'(occ) + 3'(mem_rd_en) - 3'(pop);
  assign issue       = (desc_valid || dma_busy) && cur_len != '0 && fill < 3'd2 && !desc_stop;

  assign line_valid = occ != 2'd0;
  assign line_data  = buf_data[rd_ptr];
  assign line_count = buf_count[rd_ptr];
  assign line_last  = buf_last[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || desc_stop) begin
      dma_busy  <= 1'b0;
      mem_rd_en <= 1'b0;
      remaining <= '0;
      occ       <= 2'd0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
    end else begin
      mem_rd_en <= issue;
      remaining <= issue ? cur_len - LW'(issue_bytes) : cur_len;
      dma_busy  <= desc_valid ? desc_len != '0 : dma_busy && !(pop && line_last);
      occ       <= occ + 2'(push) - 2'(pop);
      wr_ptr    <= wr_ptr ^ push;
      rd_ptr    <= rd_ptr ^ pop;
    end
  end

  always_ff @(posedge clk) begin
    if (desc_valid || issue) begin
      next_addr <= cur_addr + MEM_ADDR_WIDTH'(issue);
    end
    if (issue) begin
      mem_rd_addr <= cur_addr;
      rd_count    <= issue_bytes;
      rd_last     <= cur_len <= LW'(BYTES);
    end
    if (push) begin
      buf_data[wr_ptr]  <= mem_rd_data;
      buf_count[wr_ptr] <= rd_count;
      buf_last[wr_ptr]  <= rd_last;
    end
  end

endmodule

// File: hw/accel_width_conv.sv
module accel_width_conv #(
  parameter int DATA_WIDTH = 128
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [DATA_WIDTH-1:0]         line_data,
  input  logic [$clog2(DATA_WIDTH/8):0] line_count,
  input  logic                          line_last,
  input  logic                          line_valid,
  output logic                          line_ready,
  input  logic                          flush,
  output logic [7:0]                    byte_data,
  output logic                          byte_valid,
  output logic                          byte_last,
  output logic                          stream_done
);

  localparam int CNT_WIDTH = $clog2(DATA_WIDTH/8) + 1;

  logic [DATA_WIDTH-1:0] shift_q;
  logic [CNT_WIDTH-1:0]  cnt;
  logic                  last_q, have, final_byte, load;

  assign final_byte = have && cnt == CNT_WIDTH'(1);
  // Next line may enter as the final byte of this one leaves
  assign line_ready = !have || final_byte;
  assign load       = line_valid && line_ready;

  // Low byte first
  assign byte_data   = shift_q[7:0];
  assign byte_valid  = have;
  assign byte_last   = final_byte && last_q;
  assign stream_done = byte_last;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      have <= 1'b0;
    end else if (load) begin
      have <= 1'b1;
    end else if (final_byte) begin
      have <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= line_data;
      cnt     <= line_count;
      last_q  <= line_last;
    end else if (have) begin
      shift_q <= shift_q >> 8;
      cnt     <= cnt - CNT_WIDTH'(1);
    end
  end

endmodule

// File: hw/pattern_match_sme.sv
module pattern_match_sme (
  input  logic       clk,
  input  logic       rst,
  input  logic       sme_init,
  input  logic [7:0] byte_data,
  input  logic       byte_valid,
  output logic       match_found
);

  logic [31:0] window, next_window;
  logic        hit;

  // Newest byte enters at the bottom
  assign next_window = {window[23:0], byte_data};

  always_comb begin
    hit = 1'b0;
    for (int k = 0; k < accel_stream_pkg::SIG_COUNT; k++) begin
      if (next_window == accel_stream_pkg::SIG_TABLE[k]) begin
        hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || sme_init) begin
      window      <= '0;
      match_found <= 1'b0;
    end else if (byte_valid) begin
      window <= next_window;
      if (hit) begin
        match_found <= 1'b1;
      end
    end
  end

endmodule

// File: hash/toeplitz_hash.sv
module toeplitz_hash (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [31:0]                             hash_data,
  input  logic [1:0]                              hash_len,
  input  logic                                    hash_valid,
  input  logic                                    hash_clear,
  output logic [accel_stream_pkg::HASH_WIDTH-1:0] hash_out
);

  localparam int HW     = accel_stream_pkg::HASH_WIDTH;
  localparam int KW     = accel_stream_pkg::KEY_WIDTH;
  localparam int EXT_KW = KW + HW;

  // Zero tail keeps the window defined past the key end
  localparam logic [EXT_KW-1:0] KEY_EXT = {accel_stream_pkg::TOEPLITZ_KEY, {HW{1'b0}}};

  logic [8:0]        offset;
  logic [5:0]        nbits;
  logic [EXT_KW-1:0] key_sh;
  logic [HW-1:0]     next_hash;

  // Length 0 means a full word
  assign nbits  = (hash_len == 2'd0) ? 6'd32 : {1'b0, hash_len, 3'b000};
  assign key_sh = KEY_EXT << offset;

  always_comb begin
    next_hash = hash_out;
    for (int i = 0; i < 32; i++) begin
      if (i < nbits && hash_data[31-i]) begin
        next_hash = next_hash ^ key_sh[EXT_KW-1-i -: HW];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || hash_clear) begin
      hash_out <= '0;
      offset   <= '0;
    end else if (hash_valid) begin
      hash_out <= next_hash;
      offset   <= offset + 9'(nbits);
    end
  end

endmodule

// File: hw/accel_wrap.sv
module accel_wrap #(
  parameter int DATA_WIDTH     = 128,
  parameter int MEM_ADDR_WIDTH = 8,
  parameter int IO_ADDR_WIDTH  = 9
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     io_en,
  input  logic                                     io_wen,
  input  logic [accel_regs_pkg::IO_STRB_WIDTH-1:0] io_strb,
  input  logic [IO_ADDR_WIDTH-1:0]                 io_addr,
  input  accel_regs_pkg::io_word_t                 io_wr_data,
  output accel_regs_pkg::io_word_t                 io_rd_data,
  output logic                                     io_rd_valid,
  output logic                                     mem_rd_en,
  output logic [MEM_ADDR_WIDTH-1:0]                mem_rd_addr,
  input  logic [DATA_WIDTH-1:0]                    mem_rd_data
);

  logic [MEM_ADDR_WIDTH-1:0]              desc_addr;
  logic [accel_stream_pkg::LEN_WIDTH-1:0] desc_len;
  logic desc_valid, desc_stop, dma_busy, sme_init;
  logic [DATA_WIDTH-1:0]                  line_data;
  logic [$clog2(DATA_WIDTH/8):0]          line_count;
  logic line_last, line_valid, line_ready;
  logic [7:0] byte_data;
  logic byte_valid, byte_last, stream_done, match_found;
  logic [31:0] hash_data;
  logic [1:0]  hash_len;
  logic hash_valid, hash_clear;
  logic [accel_stream_pkg::HASH_WIDTH-1:0] hash_out;

  accel_ctrl_regs #(
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH),
    .IO_ADDR_WIDTH (IO_ADDR_WIDTH)
  ) i_ctrl_regs (.*);

  accel_rd_dma #(
    .DATA_WIDTH    (DATA_WIDTH),
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
  ) i_rd_dma (.*);

  // A stop also drops bytes held in the converter
  accel_width_conv #(
    .DATA_WIDTH(DATA_WIDTH)
  ) i_width_conv (.*, .flush(desc_stop));

  pattern_match_sme i_sme (.*);

  toeplitz_hash i_hash (.*);

endmodule

// File: dv/tb_accel_wrap.sv
module tb_accel_wrap;

  localparam int DATA_WIDTH     = 128;
  localparam int MEM_ADDR_WIDTH = 8;
  localparam int IO_ADDR_WIDTH  = 9;
  localparam int MEM_LINES      = 1 << MEM_ADDR_WIDTH;
  localparam string PATTERN_FILE = "dv/accel_test_patterns.txt";

  logic clk = 1'b0;
  logic rst;
  logic io_en;
  logic io_wen;
  logic [accel_regs_pkg::IO_STRB_WIDTH-1:0] io_strb;
  logic [IO_ADDR_WIDTH-1:0] io_addr;
  accel_regs_pkg::io_word_t io_wr_data;
  accel_regs_pkg::io_word_t io_rd_data;
  logic io_rd_valid;
  logic mem_rd_en;
  logic [MEM_ADDR_WIDTH-1:0] mem_rd_addr;
  logic [DATA_WIDTH-1:0] mem_rd_data;

  logic [DATA_WIDTH-1:0] mem [MEM_LINES];

  // Operations from the pattern file, in file order
  byte op_kind [$];
  logic [11:0] op_addr [$];
  accel_regs_pkg::io_word_t op_data [$];
  accel_regs_pkg::io_word_t op_mask [$];
  string op_name [$];

  int cycle_count = 0;
  int cycle_limit = 0;
  logic [31:0] rng_state = 32'h4e26_71ed;

  accel_wrap #(
    .DATA_WIDTH    (DATA_WIDTH),
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH),
    .IO_ADDR_WIDTH (IO_ADDR_WIDTH)
  ) i_accel_wrap (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_strb    (io_strb),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid),
    .mem_rd_en  (mem_rd_en),
    .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data)
  );

  always #2 clk = ~clk;

  // Packet memory, address registered by the DMA one cycle after its read decision
  assign mem_rd_data = mem_rd_en ? mem[mem_rd_addr] : '0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Top bit of every word is set, so no signature forms inside a fill line
  function automatic logic [DATA_WIDTH-1:0] fill_line(input int addr);
    logic [DATA_WIDTH-1:0] fill;
    logic [7:0] a;
    a = 8'(addr);
    for (int j = 0; j < DATA_WIDTH / 32; j++) begin
      fill[j*32 +: 32] = {1'b1, 7'(j), a, ~a, 8'h5a};
    end
    return fill;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_reg(input string name, input accel_regs_pkg::io_word_t expected,
                           input accel_regs_pkg::io_word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_hash(input string name,
                            input logic [accel_stream_pkg::HASH_WIDTH-1:0] expected,
                            input logic [accel_stream_pkg::HASH_WIDTH-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic add_op(input byte kind, input logic [11:0] addr,
                        input accel_regs_pkg::io_word_t data,
                        input accel_regs_pkg::io_word_t mask, input string name);
    op_kind.push_back(kind);
    op_addr.push_back(addr);
    op_data.push_back(data);
    op_mask.push_back(mask);
    op_name.push_back(name);
  endtask

  task automatic load_patterns(output int byte_total);
    int fd;
    int n;
    int maddr;
    string text;
    string rest;
    string name;
    logic [DATA_WIDTH-1:0] mline;
    logic [11:0] addr;
    accel_regs_pkg::io_word_t data;
    accel_regs_pkg::io_word_t mask;
    byte_total = 0;
    for (int a = 0; a < MEM_LINES; a++) begin
      mem[a] = fill_line(a);
    end
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      abort_run({"Could not open the pattern file ", PATTERN_FILE});
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      if (n > 0 && text.len() > 1) begin
        rest = text.substr(1, text.len() - 1);
        case (text[0])
          "M": begin
            n = $sscanf(rest, "%h %h", maddr, mline);
            mem[maddr] = mline;
          end
          "W": begin
            n = $sscanf(rest, "%h %h", addr, data);
            add_op("W", addr, data, '0, "");
            if (addr == accel_regs_pkg::REG_LEN) begin
              byte_total += int'(data);
            end
          end
          "R": begin
            n = $sscanf(rest, "%h %h %h %s", addr, data, mask, name);
            add_op("R", addr, data, mask, name);
          end
          "H": begin
            n = $sscanf(rest, "%h %s", data, name);
            add_op("H", accel_regs_pkg::REG_HASH_CLR, data, '0, name);
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Register tasks start and end one time unit after a rising edge
  task automatic reg_write(input logic [11:0] addr, input accel_regs_pkg::io_word_t data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = '1;
    io_addr    = addr[IO_ADDR_WIDTH-1:0];
    io_wr_data = data;
    @(posedge clk);
    #1;
    io_en   = 1'b0;
    io_wen  = 1'b0;
    io_strb = '0;
  endtask

  task automatic reg_read(input logic [11:0] addr, output accel_regs_pkg::io_word_t data);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr[IO_ADDR_WIDTH-1:0];
    @(posedge clk);
    #1;
    io_en = 1'b0;
    while (!io_rd_valid) begin
      @(posedge clk);
      #1;
    end
    data = io_rd_data;
  endtask

  // Repeats the read until the masked bits reach their expected state
  task automatic poll_and_check(input string name, input logic [11:0] addr,
                                input accel_regs_pkg::io_word_t expected,
                                input accel_regs_pkg::io_word_t mask);
    accel_regs_pkg::io_word_t data;
    reg_read(addr, data);
    while ((data & mask) != (expected & mask)) begin
      reg_read(addr, data);
    end
    check_reg(name, expected, data);
  endtask

  // A stop ends the run at once, long before its length runs out
  task automatic confirm_stop_ended_run;
    accel_regs_pkg::io_word_t data;
    accel_regs_pkg::io_word_t status_mask;
    accel_regs_pkg::io_word_t expected;
    status_mask = '0;
    status_mask[accel_regs_pkg::STAT_BUSY_BIT] = 1'b1;
    status_mask[accel_regs_pkg::STAT_DONE_BIT] = 1'b1;
    expected = '0;
    expected[accel_regs_pkg::STAT_DONE_BIT] = 1'b1;
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    reg_read(accel_regs_pkg::REG_CMD, data);
    check_reg("stop_ends_run", expected, data & status_mask);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      abort_run($sformatf("Run timed out after %0d cycles", cycle_count));
    end
  end

  initial begin
    accel_regs_pkg::io_word_t data;
    int byte_total;
    int gap;
    rst        = 1'b1;
    io_en      = 1'b0;
    io_wen     = 1'b0;
    io_strb    = '0;
    io_addr    = '0;
    io_wr_data = '0;
    load_patterns(byte_total);
    cycle_limit = 40 * op_kind.size() + byte_total;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (op_kind[i]) begin
      rng_state = xorshift32(rng_state);
      // Hash reads follow at once, so a read right after a hash write hits the stall
      gap = (op_kind[i] == "H") ? 0 : int'(rng_state % 4);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      case (op_kind[i])
        "W": begin
          reg_write(op_addr[i], op_data[i]);
          if (op_addr[i] == accel_regs_pkg::REG_CMD &&
              op_data[i][accel_regs_pkg::CMD_STOP_BIT]) begin
            confirm_stop_ended_run();
          end
        end
        "R": poll_and_check(op_name[i], op_addr[i], op_data[i], op_mask[i]);
        default: begin
          reg_read(op_addr[i], data);
          check_hash(op_name[i], op_data[i][accel_stream_pkg::HASH_WIDTH-1:0],
                     data[accel_stream_pkg::HASH_WIDTH-1:0]);
        end
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: dv/accel_test_patterns.txt
# M <line addr> <line data, byte 0 in the low bits>   W <reg addr> <data>
# R <reg addr> <expected> <wait mask> <test>          H <expected hash> <test>
M 10 54483d3c3b3a39383736353433323130
M 11 6e6d6c6b6a6968676665646362615054
M 20 2e2e54534f5039383736353433323130
M 31 2e2e2e2e2e2e20544547353433323130
# Register readback after reset
R 000 00000000 00000000 status_after_reset
W 004 00000025
W 008 00000010
R 004 00000025 00000000 len_readback
R 008 00000010 00000000 addr_readback
# HTTP split across lines 0x10 and 0x11
W 000 00000001
R 000 00000300 00000100 http_match
# POST cut off by the length, second start clears the match
W 004 0000000d
W 008 00000020
W 000 00000001
R 000 00000100 00000100 post_past_len
# GET just past a two-line length
W 004 00000016
W 008 00000030
W 000 00000001
R 000 00000100 00000100 get_past_len
# Stop during a long run
W 004 00000400
W 008 00000040
W 000 00000001
R 000 00000002 00000002 busy_during_run
W 000 00000010
R 000 00000100 00000100 done_after_stop
# Toeplitz hash with 4, 2 and 1 byte writes
W 100 00000000
H 00000000 hash_after_clear
W 10c 80000001
H 7ff7d1bb hash_4b
W 108 8000abcd
H 5aacdf79 hash_2b
W 104 01ffffff
H 3b8c6ceb hash_1b
H 3b8c6ceb hash_no_stall
W 100 00000000
R 008 00000040 00000000 addr_kept
H 00000000 hash_cleared

// File: filelist.f
common/accel_regs_pkg.sv
common/accel_stream_pkg.sv
hw/accel_ctrl_regs.sv
dma/accel_rd_dma.sv
hw/accel_width_conv.sv
hw/pattern_match_sme.sv
hash/toeplitz_hash.sv
hw/accel_wrap.sv
dv/tb_accel_wrap.sv
